//--- Bender.yml
package:
  name: helm

export_include_dirs:
  - hdl

sources:
  - hdl/helm_port_pkg.sv
  - hdl/helm_mem_pkg.sv
  - hdl/helm_port_decode.sv
  - hdl/helm_mem_access.sv
  - hdl/helm_activity.sv
  - hdl/helm_byte_fifo.sv
  - hdl/helm.sv
  - target: test
    files:
      - dv/helm_tb.sv

//--- dv/helm_tb.sv
// helm testbench
// port bus driver tasks, user memory model with lfsr ack delay
// directed tests for reset, memory access, byte buffer and command framing

`timescale 1ns/1ns
`default_nettype none

`include "helm_settings.svh"

module helm_tb;

    localparam int active_hold = 20;
    localparam int clk_period  = 4;
    localparam int reset_len   = 8;
    localparam int test_count  = 5;
    localparam int test_cycles = 3000;     // worst test, buffer fill and drain

    logic                     clk;
    logic                     rst_b;
    helm_port_pkg::port_bus_t bus;
    helm_mem_pkg::mem_rsp_t   mem_rsp;
    logic [15:0]              ack_timeout_lim;
    logic [7:0]               in_port;
    helm_mem_pkg::mem_req_t   mem_req;
    logic [7:0]               cmd_type;
    logic                     msg_processing;
    logic                     active;

    logic [7:0]  mem_model [256];      // indexed by page ^ offset
    logic [31:0] lfsr;
    logic [7:0]  delay_draw;
    logic        model_silent;         // never acks when set
    logic        model_busy;
    logic        model_cool;           // enable still high the edge after ack
    logic [2:0]  model_delay;
    int          mismatches;
    int          failures;

    helm #(.active_timeout(active_hold)) u_helm (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[6:0], lfsr[0]};
        end
    endtask

    // bit 4 mem_done, bit 3 full, bit 2 empty
    function automatic logic [7:0] status_byte(input logic done, input logic full,
                                               input logic empty);
        return {3'b000, done, full, empty, 2'b00};
    endfunction

    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp) else begin
            mismatches++;
            $display("mismatch %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            failures++;
            $display("error: %s", what);
        end
    endtask

    task automatic port_write(input logic [7:0] id, input logic [7:0] data);
        @(posedge clk);
        bus <= '{port_id: id, out_port: data, write_strobe: 1'b1, read_strobe: 1'b0};
        @(posedge clk);
        bus.write_strobe <= 1'b0;
    endtask

    // strobe on the buffer port also pops it
    task automatic port_read(input logic [7:0] id, output logic [7:0] data);
        @(posedge clk);
        bus.port_id     <= id;
        bus.read_strobe <= 1'b1;
        @(posedge clk);
        bus.read_strobe <= 1'b0;
        @(negedge clk);
        data = in_port;                // registered from port_id one edge ago
    endtask

    // ------------------------------
    // user memory model
    // ------------------------------
    always @(posedge clk) begin
        if (!rst_b) begin
            mem_rsp    <= '0;
            model_busy <= 1'b0;
            model_cool <= 1'b0;
        end else begin
            mem_rsp.ack <= 1'b0;
            model_cool  <= 1'b0;
            if (model_busy && model_delay == 3'd0) begin
                mem_rsp <= '{rd_data: mem_model[mem_req.page ^ mem_req.offset], ack: 1'b1};
                if (mem_req.wr_en) begin
                    mem_model[mem_req.page ^ mem_req.offset] <= mem_req.wr_data;
                end
                model_busy <= 1'b0;
                model_cool <= 1'b1;
            end else if (model_busy) begin
                model_delay <= model_delay - 1'b1;
            end else if (!model_cool && !model_silent && (mem_req.wr_en || mem_req.rd_en)) begin
                draw_bits(3, delay_draw);      // 0 to 7 cycles
                model_delay <= delay_draw[2:0];
                model_busy  <= 1'b1;
            end
        end
    end

    // follow one access from the enable strobe until the enable drops
    task automatic watch_access(input string name, input logic [7:0] pg, input logic [7:0] ofs,
                                input logic [7:0] wd, input logic wr, input int max_cycles,
                                output logic acked);
        logic seen_high;
        int   n;
        seen_high = 1'b0;
        acked     = 1'b0;
        n         = 0;
        while (n < max_cycles && !(seen_high && !(mem_req.wr_en || mem_req.rd_en))) begin
            @(negedge clk);
            n++;
            if (mem_req.wr_en || mem_req.rd_en) begin
                seen_high = 1'b1;
                compare_byte({name, " page"}, pg, mem_req.page);
                compare_byte({name, " offset"}, ofs, mem_req.offset);
                compare_byte({name, " wr_data"}, wd, mem_req.wr_data);
                // wr_en alone for a write, rd_en alone for a read
                compare_byte({name, " enables"}, {6'b000000, wr, ~wr},
                             {6'b000000, mem_req.wr_en, mem_req.rd_en});
                acked |= mem_rsp.ack;
            end
        end
        require(seen_high && !(mem_req.wr_en || mem_req.rd_en),
                {name, ": enable did not rise and drop in time"});
    endtask

    task automatic wait_done(input string name);
        logic [7:0] st;
        int         n;
        st = 8'h00;
        n  = 0;
        while (!st[4] && n < 20) begin
            port_read(`HELM_PORT_STATUS, st);
            n++;
        end
        require(st[4], {name, ": mem_done never set"});
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic reset_state();
        logic [7:0] rd;
        @(negedge clk);
        require(!mem_req.wr_en && !mem_req.rd_en, "reset: memory enables not low");
        require(!msg_processing && !active, "reset: msg_processing or active not low");
        port_read(`HELM_PORT_STATUS, rd);
        compare_byte("reset status", status_byte(1'b0, 1'b0, 1'b1), rd);
    endtask

    task automatic write_access();
        logic acked;
        port_write(`HELM_PORT_MEM_PAGE, 8'h12);
        port_write(`HELM_PORT_MEM_OFFSET, 8'h34);
        port_write(`HELM_PORT_MEM_WR_DATA, 8'h5a);
        port_write(`HELM_PORT_MEM_WR_EN, 8'h01);
        watch_access("write", 8'h12, 8'h34, 8'h5a, 1'b1, 40, acked);
        require(acked, "write: enable dropped without an ack");
        wait_done("write");
        compare_byte("write model data", 8'h5a, mem_model[8'h12 ^ 8'h34]);
        port_write(`HELM_PORT_MEM_WR_EN, 8'h00);   // level back to 0 for the next edge
    endtask

    task automatic read_access();
        logic       acked;
        logic [7:0] rd;
        logic [7:0] exp;
        exp = mem_model[8'h21 ^ 8'h0f];
        port_write(`HELM_PORT_MEM_PAGE, 8'h21);
        port_write(`HELM_PORT_MEM_OFFSET, 8'h0f);
        port_write(`HELM_PORT_MEM_RD_EN, 8'h00);
        port_write(`HELM_PORT_MEM_RD_EN, 8'h01);
        watch_access("read", 8'h21, 8'h0f, 8'h5a, 1'b0, 40, acked);
        require(acked, "read: enable dropped without an ack");
        wait_done("read");
        port_read(`HELM_PORT_MEM_RD_DATA, rd);
        compare_byte("read data", exp, rd);
        // silent memory, ends on timeout
        model_silent = 1'b1;
        @(posedge clk);
        ack_timeout_lim <= 16'd10;
        port_write(`HELM_PORT_MEM_RD_EN, 8'h00);
        port_write(`HELM_PORT_MEM_RD_EN, 8'h01);
        watch_access("read timeout", 8'h21, 8'h0f, 8'h5a, 1'b0, 15, acked);
        wait_done("read timeout");
        port_read(`HELM_PORT_MEM_RD_DATA, rd);
        compare_byte("read timeout data", 8'hac, rd);
        model_silent = 1'b0;
        port_write(`HELM_PORT_MEM_RD_EN, 8'h00);
    endtask

    task automatic buffer_order();
        logic [7:0] q [$];
        logic [7:0] b;
        logic [7:0] rd;
        port_read(`HELM_PORT_STATUS, rd);
        compare_byte("buffer start status", status_byte(1'b1, 1'b0, 1'b1), rd);
        for (int i = 0; i < `HELM_BUF_DEPTH + 2; i++) begin
            draw_bits(8, b);
            port_write(`HELM_PORT_BUF_DATA, b);
            if (i < `HELM_BUF_DEPTH) begin
                q.push_back(b);        // last two land on a full buffer
            end
            if (i == 0) begin
                port_read(`HELM_PORT_STATUS, rd);
                compare_byte("buffer one entry status", status_byte(1'b1, 1'b0, 1'b0), rd);
            end
        end
        port_read(`HELM_PORT_STATUS, rd);
        compare_byte("buffer full status", status_byte(1'b1, 1'b1, 1'b0), rd);
        for (int i = 0; i < `HELM_BUF_DEPTH; i++) begin
            port_read(`HELM_PORT_BUF_DATA, rd);
            compare_byte("buffer data", q.pop_front(), rd);
        end
        port_read(`HELM_PORT_STATUS, rd);
        compare_byte("buffer drained status", status_byte(1'b1, 1'b0, 1'b1), rd);
    endtask

    task automatic command_framing();
        int n;
        port_write(`HELM_PORT_CMD_START, 8'h3c);
        n = 0;
        while (!msg_processing && n < 4) begin
            @(negedge clk);
            n++;
        end
        require(msg_processing, "command: msg_processing did not rise after start");
        compare_byte("command type", 8'h3c, cmd_type);
        @(negedge clk);
        require(active, "command: active low while processing");
        port_write(`HELM_PORT_CMD_END, 8'h00);
        n = 0;
        while (msg_processing && n < 4) begin
            @(negedge clk);
            n++;
        end
        require(!msg_processing, "command: msg_processing did not fall after end");
        n = 0;
        while (active && n < active_hold + 10) begin
            n++;
            @(negedge clk);
        end
        compare_byte("active hold cycles", 8'(active_hold + 1), 8'(n));
    endtask

    // ------------------------------
    // run control
    // ------------------------------
    initial begin
        mismatches      = 0;
        failures        = 0;
        lfsr            = 32'h6032;
        model_silent    = 1'b0;
        rst_b           = 1'b0;
        bus             = '0;
        mem_rsp         = '0;
        ack_timeout_lim = 16'd0;       // timeout off until the silent read
        for (int i = 0; i < 256; i++) begin
            mem_model[i] = 8'(i * 37 + 11);
        end
        repeat (reset_len) @(posedge clk);
        rst_b <= 1'b1;
        reset_state();
        write_access();
        read_access();
        buffer_order();
        command_framing();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #((reset_len + test_count * test_cycles) * clk_period);
        $display("watchdog: run did not finish in %0d cycles",
                 reset_len + test_count * test_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/helm_port_pkg.sv
hdl/helm_mem_pkg.sv
hdl/helm_port_decode.sv
hdl/helm_mem_access.sv
hdl/helm_activity.sv
hdl/helm_byte_fifo.sv
hdl/helm.sv
dv/helm_tb.sv

//--- hdl/helm.sv
// helm control core top level
// port decode, user memory request engine, activity timer, byte buffer

`timescale 1ns/1ns
`default_nettype none

`include "helm_settings.svh"

module helm #(
    parameter int active_timeout = `HELM_ACTIVE_TIMEOUT
) (
    input  wire                           clk,
    input  wire                           rst_b,
    input  wire helm_port_pkg::port_bus_t bus,
    input  wire helm_mem_pkg::mem_rsp_t   mem_rsp,
    input  wire [15:0]                    ack_timeout_lim,
    output logic [7:0]                    in_port,
    output helm_mem_pkg::mem_req_t        mem_req,
    output logic [7:0]                    cmd_type,
    output logic                          msg_processing,
    output logic                          active
);

    helm_mem_pkg::mem_req_t mem_ctl;       // controller side request
    logic [7:0] mem_rd_data;
    logic       mem_done;
    logic [7:0] buf_head;
    logic       buf_full;
    logic       buf_empty;
    logic       buf_push;
    logic [7:0] buf_wr_data;
    logic       buf_pop;
    logic       cmd_start;
    logic       cmd_end;

    helm_port_decode u_decode (
        .clk         (clk),
        .rst_b       (rst_b),
        .bus         (bus),
        .mem_rd_data (mem_rd_data),
        .mem_done    (mem_done),
        .buf_head    (buf_head),
        .buf_full    (buf_full),
        .buf_empty   (buf_empty),
        .in_port     (in_port),
        .mem_ctl     (mem_ctl),
        .buf_push    (buf_push),
        .buf_wr_data (buf_wr_data),
        .buf_pop     (buf_pop),
        .cmd_start   (cmd_start),
        .cmd_end     (cmd_end),
        .cmd_type    (cmd_type)
    );

    helm_mem_access u_mem (
        .clk             (clk),
        .rst_b           (rst_b),
        .ctl             (mem_ctl),
        .ack_timeout_lim (ack_timeout_lim),
        .rsp             (mem_rsp),
        .req             (mem_req),
        .rd_data         (mem_rd_data),
        .done            (mem_done)
    );

    helm_activity #(.active_timeout(active_timeout)) u_activity (
        .clk            (clk),
        .rst_b          (rst_b),
        .cmd_start      (cmd_start),
        .cmd_end        (cmd_end),
        .msg_processing (msg_processing),
        .active         (active)
    );

    helm_byte_fifo #(.depth(`HELM_BUF_DEPTH)) u_buf (
        .clk     (clk),
        .rst_b   (rst_b),
        .push    (buf_push),
        .wr_data (buf_wr_data),
        .pop     (buf_pop),
        .head    (buf_head),
        .full    (buf_full),
        .empty   (buf_empty)
    );

endmodule

`default_nettype wire

//--- hdl/helm_activity.sv
// helm activity tracking
// msg_processing level from start and end commands
// active hold countdown after processing ends

`timescale 1ns/1ns
`default_nettype none

`include "helm_settings.svh"

module helm_activity #(
    parameter int active_timeout = `HELM_ACTIVE_TIMEOUT   // hold in clk cycles
) (
    input  wire  clk,
    input  wire  rst_b,
    input  wire  cmd_start,
    input  wire  cmd_end,
    output logic msg_processing,
    output logic active
);

    localparam int tw = (active_timeout > 0) ? $clog2(active_timeout + 1) : 1;

    logic [tw-1:0] active_timer;

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            msg_processing <= 1'b0;
            active         <= 1'b0;
            active_timer   <= '0;
        end else begin
            if (cmd_start) begin
                msg_processing <= 1'b1;
            end else if (cmd_end) begin
                msg_processing <= 1'b0;
            end

            if (msg_processing) begin
                active       <= 1'b1;
                active_timer <= tw'(active_timeout);    // reload while busy
            end else if (active_timer != '0) begin
                active_timer <= active_timer - 1'b1;
            end else begin
                active <= 1'b0;    // hold ran out
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/helm_byte_fifo.sv
// helm internal byte buffer
// first word fall through, head shows the oldest byte
// push to full and pop of empty are dropped

`timescale 1ns/1ns
`default_nettype none

`include "helm_settings.svh"

module helm_byte_fifo #(
    parameter int depth = `HELM_BUF_DEPTH
) (
    input  wire        clk,
    input  wire        rst_b,
    input  wire        push,
    input  wire  [7:0] wr_data,
    input  wire        pop,
    output logic [7:0] head,
    output logic       full,
    output logic       empty
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;

    logic [7:0]    mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;          // one extra bit to hold depth
    logic          do_push;
    logic          do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign empty = (count == '0);
    assign full  = (count == (aw + 1)'(depth));
    assign head  = mem[rd_ptr];    // async read, fall through

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // ------------------------------
    // pointers and count
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/helm_mem_access.sv
// helm user memory request engine
// rising edge of controller wr_en / rd_en starts an access
// access ends on ack or on ack timeout, captures read data or timeout byte

`timescale 1ns/1ns
`default_nettype none

`include "helm_settings.svh"

module helm_mem_access (
    input  wire                          clk,
    input  wire                          rst_b,
    input  wire helm_mem_pkg::mem_req_t  ctl,
    input  wire [15:0]                   ack_timeout_lim,   // 0 disables the timeout
    input  wire helm_mem_pkg::mem_rsp_t  rsp,
    output helm_mem_pkg::mem_req_t       req,
    output logic [7:0]                   rd_data,
    output logic                         done
);

    logic        wr_en_d1;         // previous controller levels
    logic        rd_en_d1;
    logic        wr_en_q;          // external enables
    logic        rd_en_q;
    logic [15:0] ack_timer;
    logic        timed_out;
    logic        start;
    logic        busy;
    logic        finish;

    // 0 to 1 on either controller level
    assign start  = (ctl.wr_en & ~wr_en_d1) | (ctl.rd_en & ~rd_en_d1);
    assign busy   = wr_en_q | rd_en_q;
    assign finish = busy & (rsp.ack | timed_out);

    // address and data straight from the decode registers
    assign req = '{page: ctl.page, offset: ctl.offset, wr_data: ctl.wr_data,
                   wr_en: wr_en_q, rd_en: rd_en_q};

    // ------------------------------
    // access control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            wr_en_d1  <= 1'b0;
            rd_en_d1  <= 1'b0;
            wr_en_q   <= 1'b0;
            rd_en_q   <= 1'b0;
            done      <= 1'b0;
            ack_timer <= 16'd0;
            timed_out <= 1'b0;
        end else begin
            wr_en_d1 <= ctl.wr_en;
            rd_en_d1 <= ctl.rd_en;

            // one cycle flag, suppressed once the access ends or restarts
            timed_out <= busy && (ack_timeout_lim != 16'd0) &&
                         (ack_timer == ack_timeout_lim) && !finish && !start;

            if (start) begin
                wr_en_q   <= ctl.wr_en;
                rd_en_q   <= ctl.rd_en;
                done      <= 1'b0;     // cleared by the next edge only
                ack_timer <= 16'd0;
            end else if (finish) begin
                wr_en_q   <= 1'b0;
                rd_en_q   <= 1'b0;
                done      <= 1'b1;
                ack_timer <= 16'd0;
            end else if (busy && (ack_timer < ack_timeout_lim)) begin
                ack_timer <= ack_timer + 16'd1;  // saturates at the limit
            end
        end
    end

    // ------------------------------
    // read data capture
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!start && finish) begin
            rd_data <= rsp.ack ? rsp.rd_data : `HELM_TIMEOUT_BYTE;
        end
    end

endmodule

`default_nettype wire

//--- hdl/helm_mem_pkg.sv
// user memory types for helm
// request from helm and response from the user memory

`default_nettype none

package helm_mem_pkg;

    // page, offset and wr_data stay put for the whole access
    typedef struct packed {
        logic [7:0] page;
        logic [7:0] offset;
        logic [7:0] wr_data;
        logic       wr_en;         // held until ack or timeout
        logic       rd_en;         // held until ack or timeout
    } mem_req_t;

    // ack is a single cycle pulse
    typedef struct packed {
        logic [7:0] rd_data;       // sampled on ack
        logic       ack;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- hdl/helm_port_decode.sv
// helm port bus decode
// write ports into memory registers, levels and one cycle pulses
// registered read mux and buffer pop from the read strobe

`timescale 1ns/1ns
`default_nettype none

`include "helm_settings.svh"

module helm_port_decode (
    input  wire                           clk,
    input  wire                           rst_b,
    input  wire helm_port_pkg::port_bus_t bus,
    input  wire [7:0]                     mem_rd_data,
    input  wire                           mem_done,
    input  wire [7:0]                     buf_head,
    input  wire                           buf_full,
    input  wire                           buf_empty,
    output logic [7:0]                    in_port,
    output helm_mem_pkg::mem_req_t        mem_ctl,
    output logic                          buf_push,
    output logic [7:0]                    buf_wr_data,
    output logic                          buf_pop,
    output logic                          cmd_start,
    output logic                          cmd_end,
    output logic [7:0]                    cmd_type
);

    logic [7:0] page_q;
    logic [7:0] offset_q;
    logic [7:0] wr_data_q;
    logic       wr_en_q;           // controller level, edge detected downstream
    logic       rd_en_q;
    helm_port_pkg::status_t status;

    assign mem_ctl = '{page: page_q, offset: offset_q, wr_data: wr_data_q,
                       wr_en: wr_en_q, rd_en: rd_en_q};

    assign status = '{spare_hi: 3'b000, mem_done: mem_done, buf_full: buf_full,
                      buf_empty: buf_empty, spare_lo: 2'b00};

    // ------------------------------
    // write side
    // ------------------------------
    // data bytes
    always_ff @(posedge clk) begin
        if (bus.write_strobe) begin
            case (bus.port_id)
                `HELM_PORT_MEM_PAGE:    page_q      <= bus.out_port;
                `HELM_PORT_MEM_OFFSET:  offset_q    <= bus.out_port;
                `HELM_PORT_MEM_WR_DATA: wr_data_q   <= bus.out_port;
                `HELM_PORT_BUF_DATA:    buf_wr_data <= bus.out_port;
                `HELM_PORT_CMD_START:   cmd_type    <= bus.out_port;  // kept for the whole msg
                default: ;
            endcase
        end
    end

    // levels and pulses
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            wr_en_q   <= 1'b0;
            rd_en_q   <= 1'b0;
            buf_push  <= 1'b0;
            buf_pop   <= 1'b0;
            cmd_start <= 1'b0;
            cmd_end   <= 1'b0;
        end else begin
            buf_push  <= 1'b0;     // pulses default low
            cmd_start <= 1'b0;
            cmd_end   <= 1'b0;
            // pop one cycle after the read strobe
            buf_pop   <= bus.read_strobe && (bus.port_id == `HELM_PORT_BUF_DATA);
            if (bus.write_strobe) begin
                case (bus.port_id)
                    `HELM_PORT_MEM_RD_EN: rd_en_q   <= bus.out_port[0];
                    `HELM_PORT_MEM_WR_EN: wr_en_q   <= bus.out_port[0];
                    `HELM_PORT_BUF_DATA:  buf_push  <= 1'b1;
                    `HELM_PORT_CMD_START: cmd_start <= 1'b1;
                    `HELM_PORT_CMD_END:   cmd_end   <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    // follows port_id every cycle, strobe not needed
    always_ff @(posedge clk) begin
        case (bus.port_id)
            `HELM_PORT_STATUS:      in_port <= status;
            `HELM_PORT_MEM_RD_DATA: in_port <= mem_rd_data;
            `HELM_PORT_BUF_DATA:    in_port <= buf_head;   // fwft head, no pop needed
            default:                in_port <= 8'h00;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/helm_port_pkg.sv
// controller side types for helm
// port bus as driven by the 8-bit controller
// status byte layout returned on the status read port

`default_nettype none

package helm_port_pkg;

    // ------------------------------
    // port bus
    // ------------------------------
    // one write or read per strobe, port_id selects the target
    typedef struct packed {
        logic [7:0] port_id;       // port number
        logic [7:0] out_port;      // write byte from controller
        logic       write_strobe;  // one cycle write
        logic       read_strobe;   // one cycle read, pops buffer on its port
    } port_bus_t;

    // ------------------------------
    // status byte
    // ------------------------------
    // bit 7 down to bit 0
    // low two bits were the serial flags, tied to zero now
    typedef struct packed {
        logic [2:0] spare_hi;      // zero
        logic       mem_done;      // bit 4, user memory access finished
        logic       buf_full;      // bit 3
        logic       buf_empty;     // bit 2
        logic [1:0] spare_lo;      // zero
    } status_t;

endpackage

`default_nettype wire

//--- hdl/helm_settings.svh
// helm settings macros
// controller port numbers, timeout read byte, buffer depth, active hold

`ifndef HELM_SETTINGS_SVH
`define HELM_SETTINGS_SVH

// write ports
`define HELM_PORT_MEM_PAGE     8'd1
`define HELM_PORT_MEM_OFFSET   8'd2
`define HELM_PORT_MEM_WR_DATA  8'd3
`define HELM_PORT_MEM_RD_EN    8'd4
`define HELM_PORT_MEM_WR_EN    8'd5
`define HELM_PORT_BUF_DATA     8'd7    // also the read port for the buffer head
`define HELM_PORT_CMD_START    8'd250
`define HELM_PORT_CMD_END      8'd252

// read ports
`define HELM_PORT_STATUS       8'd1
`define HELM_PORT_MEM_RD_DATA  8'd3

`define HELM_TIMEOUT_BYTE      8'hac   // read data after an ack timeout
`define HELM_BUF_DEPTH         256     // internal byte buffer entries
`define HELM_ACTIVE_TIMEOUT    1000    // clk cycles active holds after processing

`endif
